//--- verilog/uart_frame_pkg.sv
package uart_frame_pkg;

  // one payload character on the line
  typedef logic [7:0] byte_t;

  // slot index inside a frame, 0 is the start bit
  typedef logic [3:0] bit_cnt_t;

  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;

  // slot numbers of the framing bits
  localparam bit_cnt_t SLOT_START  = bit_cnt_t'(0);
  localparam bit_cnt_t SLOT_PARITY = bit_cnt_t'(FRAME_BITS - 2);
  localparam bit_cnt_t SLOT_STOP   = bit_cnt_t'(FRAME_BITS - 1);

  // idle and stop level, start bit is the inverse
  localparam logic line_idle = 1'b1;

  // odd parity bit for one character
  function automatic logic odd_parity(input byte_t data);
    return ~^data;
  endfunction

endpackage

//--- verilog/bridge_cmd_pkg.sv
package bridge_cmd_pkg;

  // host command word
  typedef logic [15:0] cmd_t;

  // bit 15 set means a reply byte is expected
  localparam int CMD_READ_BIT = 15;

  // byte lanes, high byte goes out first
  localparam int CMD_HI_LSB = 8;
  localparam int CMD_LO_LSB = 0;

  // sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_SEND_LO,
    ST_WAIT_RSP
  } seq_state_t;

endpackage

//--- verilog/uart_tx.sv
`timescale 1ns/1ns

module uart_tx
  import uart_frame_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  tx,
  output logic  tx_busy,
  output logic  tx_done
);

  localparam int TW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [TW-1:0] TIMER_LAST = TW'(CLKS_PER_BIT - 1);

  logic [FRAME_BITS-1:0] frame;
  logic [FRAME_BITS-1:0] shreg;
  logic [TW-1:0]         bit_timer;
  bit_cnt_t              slot;
  logic                  bit_end;

  // stop, parity, data, start from msb down
  assign frame = {line_idle, odd_parity(tx_byte), tx_byte, ~line_idle};

  assign bit_end = tx_busy && (bit_timer == TIMER_LAST);
  assign tx_done = bit_end && (slot == SLOT_STOP);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy   <= 1'b0;
      tx        <= line_idle;
      bit_timer <= '0;
      slot      <= SLOT_START;
    end else if (tx_start) begin
      tx_busy   <= 1'b1;
      tx        <= frame[0];
      bit_timer <= '0;
      slot      <= SLOT_START;
    end else if (bit_end) begin
      bit_timer <= '0;
      if (slot == SLOT_STOP) begin
        tx_busy <= 1'b0;
        tx      <= line_idle;
      end else begin
        slot <= slot + 1'b1;
        // shreg[0] is the bit on the line now
        tx   <= shreg[1];
      end
    end else if (tx_busy) begin
      bit_timer <= bit_timer + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_start) begin
      shreg <= frame;
    end else if (bit_end) begin
      shreg <= {line_idle, shreg[FRAME_BITS-1:1]};
    end
  end

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !tx_busy |-> (tx == line_idle)
  );

  a_no_start_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  );

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/1ns

module uart_rx
  import uart_frame_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int PARITY_CHECK = 1
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  input  logic  rx_arm,
  output logic  rx_start_seen,
  output logic  rx_valid,
  output byte_t rx_byte,
  output logic  rx_parity_err
);

  localparam int TW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [TW-1:0] TIMER_LAST = TW'(CLKS_PER_BIT - 1);
  localparam logic [TW-1:0] HALF_LOAD  = TW'(CLKS_PER_BIT / 2 - 1);

  logic          rx_meta;
  logic          rx_sync;
  logic          rx_prev;
  logic          busy;
  bit_cnt_t      slot;
  logic [TW-1:0] bit_timer;
  logic          par_q;
  logic          fall;
  logic          tick;
  logic          par_bad;
  logic          stop_bad;

  // two flops against metastability, third one for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= line_idle;
      rx_sync <= line_idle;
      rx_prev <= line_idle;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_arm && !busy && (rx_prev == line_idle) && (rx_sync != line_idle);

  // down counter, zero marks the middle of a slot
  assign tick = busy && (bit_timer == '0);

  assign rx_start_seen = tick && (slot == SLOT_START) && (rx_sync != line_idle);
  assign rx_valid      = tick && (slot == SLOT_STOP);

  assign par_bad       = (PARITY_CHECK != 0) && (odd_parity(rx_byte) != par_q);
  assign stop_bad      = (rx_sync != line_idle);
  assign rx_parity_err = par_bad || stop_bad;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      slot      <= SLOT_START;
      bit_timer <= '0;
    end else if (!rx_arm) begin
      busy <= 1'b0;
    end else if (fall) begin
      busy      <= 1'b1;
      slot      <= SLOT_START;
      bit_timer <= HALF_LOAD;
    end else if (tick) begin
      bit_timer <= TIMER_LAST;
      if (slot == SLOT_START && rx_sync == line_idle) begin
        // line went back high, just a glitch
        busy <= 1'b0;
      end else if (slot == SLOT_STOP) begin
        busy <= 1'b0;
      end else begin
        slot <= slot + 1'b1;
      end
    end else if (busy) begin
      bit_timer <= bit_timer - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tick && slot != SLOT_START && slot < SLOT_PARITY) begin
      // lsb arrives first
      rx_byte <= {rx_sync, rx_byte[DATA_BITS-1:1]};
    end
    if (tick && slot == SLOT_PARITY) begin
      par_q <= rx_sync;
    end
  end

  a_valid_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid
  );

endmodule

//--- verilog/cmd_sequencer.sv
`timescale 1ns/1ns

module cmd_sequencer
  import uart_frame_pkg::*, bridge_cmd_pkg::*;
#(
  parameter int RSP_TIMEOUT = 100000
) (
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  output logic  tx_start,
  output byte_t tx_byte,
  input  logic  tx_busy,
  input  logic  tx_done,
  output logic  rx_arm,
  input  logic  rx_start_seen,
  input  logic  rx_valid,
  input  byte_t rx_byte,
  input  logic  rx_parity_err,
  output byte_t read_data,
  output logic  read_err,
  output logic  read_rdy,
  output logic  rsp_timeout
);

  localparam int TOW = $clog2(RSP_TIMEOUT + 1);
  localparam logic [TOW-1:0] TO_LAST = TOW'(RSP_TIMEOUT - 1);

  seq_state_t     state;
  cmd_t           cmd_q;
  logic           start_seen;
  logic [TOW-1:0] to_cnt;
  logic           accept;
  logic           is_read;

  assign accept  = cmd_vld && cmd_rdy;
  assign is_read = cmd_q[CMD_READ_BIT];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      cmd_rdy     <= 1'b1;
      tx_start    <= 1'b0;
      rx_arm      <= 1'b0;
      start_seen  <= 1'b0;
      to_cnt      <= '0;
      read_rdy    <= 1'b0;
      rsp_timeout <= 1'b0;
    end else begin
      tx_start    <= 1'b0;
      read_rdy    <= 1'b0;
      rsp_timeout <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state    <= ST_SEND_HI;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
          end
        end
        ST_SEND_HI: begin
          if (tx_done) begin
            state    <= ST_SEND_LO;
            tx_start <= 1'b1;
          end
        end
        ST_SEND_LO: begin
          if (tx_done) begin
            if (is_read) begin
              state      <= ST_WAIT_RSP;
              rx_arm     <= 1'b1;
              start_seen <= 1'b0;
              to_cnt     <= '0;
            end else begin
              state   <= ST_IDLE;
              cmd_rdy <= 1'b1;
            end
          end
        end
        ST_WAIT_RSP: begin
          if (rx_valid) begin
            state    <= ST_IDLE;
            cmd_rdy  <= 1'b1;
            rx_arm   <= 1'b0;
            read_rdy <= 1'b1;
          end else if (rx_start_seen) begin
            // reply under way, window no longer applies
            start_seen <= 1'b1;
          end else if (!start_seen) begin
            if (to_cnt == TO_LAST) begin
              state       <= ST_IDLE;
              cmd_rdy     <= 1'b1;
              rx_arm      <= 1'b0;
              rsp_timeout <= 1'b1;
            end else begin
              to_cnt <= to_cnt + 1'b1;
            end
          end
        end
        default: begin
          state   <= ST_IDLE;
          cmd_rdy <= 1'b1;
          rx_arm  <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q   <= cmd_in;
      tx_byte <= cmd_in[CMD_HI_LSB +: DATA_BITS];
    end else if (state == ST_SEND_HI && tx_done) begin
      tx_byte <= cmd_q[CMD_LO_LSB +: DATA_BITS];
    end
    if (state == ST_WAIT_RSP && rx_valid) begin
      read_data <= rx_byte;
      read_err  <= rx_parity_err;
    end
  end

  a_rdy_only_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_rdy == (state == ST_IDLE)
  );

  // transmitter must be free again by the time a new command can come in
  a_tx_free_when_rdy: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> !tx_busy
  );

endmodule

//--- verilog/uart_cmd_bridge.sv
`timescale 1ns/1ns

module uart_cmd_bridge
  import uart_frame_pkg::*, bridge_cmd_pkg::*;
#(
  parameter int CLK_FREQ     = 50000000,
  parameter int BAUD         = 115200,
  parameter int RSP_TIMEOUT  = 100000,
  parameter int PARITY_CHECK = 1
) (
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  output logic  tx,
  input  logic  rx,
  output byte_t read_data,
  output logic  read_err,
  output logic  read_rdy,
  output logic  rsp_timeout
);

  // rounded down, small baud error at odd ratios
  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD;

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;
  logic  tx_done;
  logic  rx_arm;
  logic  rx_start_seen;
  logic  rx_valid;
  byte_t rx_byte;
  logic  rx_parity_err;

  cmd_sequencer #(
    .RSP_TIMEOUT (RSP_TIMEOUT)
  ) u_cmd_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .tx_done       (tx_done),
    .rx_arm        (rx_arm),
    .rx_start_seen (rx_start_seen),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .read_data     (read_data),
    .read_err      (read_err),
    .read_rdy      (read_rdy),
    .rsp_timeout   (rsp_timeout)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_CHECK (PARITY_CHECK)
  ) u_uart_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_arm        (rx_arm),
    .rx_start_seen (rx_start_seen),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err)
  );

endmodule

//--- sim/tb_uart_cmd_bridge.sv
`timescale 1ns/1ns

module tb_uart_cmd_bridge
  import uart_frame_pkg::*, bridge_cmd_pkg::*;
();

  localparam int CLK_FREQ    = 10000000;
  localparam int BAUD        = 1000000;
  localparam int RSP_TIMEOUT = 400;
  localparam int BIT_CLKS    = CLK_FREQ / BAUD;

  logic        clk = 1'b0;
  logic        rst_n;
  cmd_t        cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        tx;
  logic        rx;
  byte_t       read_data;
  logic        read_err;
  logic        read_rdy;
  logic        rsp_timeout;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          rdy_pulses = 0;
  int          to_pulses = 0;
  byte_t       got_data;
  logic        got_err;
  logic [31:0] seed = 32'd90220;

  uart_cmd_bridge #(
    .CLK_FREQ     (CLK_FREQ),
    .BAUD         (BAUD),
    .RSP_TIMEOUT  (RSP_TIMEOUT),
    .PARITY_CHECK (1)
  ) u_uart_cmd_bridge (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .tx          (tx),
    .rx          (rx),
    .read_data   (read_data),
    .read_err    (read_err),
    .read_rdy    (read_rdy),
    .rsp_timeout (rsp_timeout)
  );

  always #50 clk = ~clk;

  // count result pulses, keep the reply seen with read_rdy
  always @(negedge clk) begin
    if (rst_n && read_rdy) begin
      rdy_pulses = rdy_pulses + 1;
      got_data   = read_data;
      got_err    = read_err;
    end
    if (rst_n && rsp_timeout) begin
      to_pulses = to_pulses + 1;
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %0t %s: got %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic probe(input string what);
    if (what == "tx start bit") begin
      return !tx;
    end
    return cmd_rdy;
  endfunction

  task automatic wait_for(input string what, input int limit);
    int n;
    n = 0;
    while (!probe(what) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!probe(what)) begin
      $display("timeout: %s not seen within %0d cycles", what, limit);
      errors++;
    end
  endtask

  // line model, samples tx in the middle of every bit
  task automatic decode_frame(output byte_t data);
    data = '0;
    wait_for("tx start bit", 300);
    repeat (BIT_CLKS / 2 - 1) @(negedge clk);
    if (tx !== 1'b0) begin
      $display("start bit on tx did not last to mid-bit at %0t", $time);
      errors++;
    end
    check_flag("cmd_rdy", cmd_rdy, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      data[i] = tx;
    end
    repeat (BIT_CLKS) @(negedge clk);
    if ((^{data, tx}) !== 1'b1) begin
      $display("parity bit on tx is not odd parity for %h at %0t", data, $time);
      errors++;
    end
    repeat (BIT_CLKS) @(negedge clk);
    if (tx !== 1'b1) begin
      $display("stop bit on tx is missing at %0t", $time);
      errors++;
    end
  endtask

  // remote device, bad_par inverts the parity bit
  task automatic send_reply(input byte_t data, input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx = bits[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic run_cmd(input cmd_t cmd, input logic answer, input byte_t rsp,
                         input logic bad_par, input int gap, input logic intrude,
                         input cmd_t other);
    int    r0;
    int    t0;
    byte_t hi;
    byte_t lo;
    wait_for("cmd_rdy", 50);
    r0 = rdy_pulses;
    t0 = to_pulses;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    check_flag("cmd_rdy after accept", cmd_rdy, 1'b0);
    if (intrude) begin
      // second word while busy, must be dropped
      cmd_in = other;
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    decode_frame(hi);
    check_byte("tx high byte", hi, cmd[15:8]);
    decode_frame(lo);
    check_byte("tx low byte", lo, cmd[7:0]);
    if (cmd[CMD_READ_BIT] && answer) begin
      repeat (gap) @(negedge clk);
      send_reply(rsp, bad_par);
    end
    wait_for("cmd_rdy", RSP_TIMEOUT + 200);
    @(negedge clk);
    if (!cmd[CMD_READ_BIT]) begin
      check_flag("read_rdy pulsed", rdy_pulses != r0, 1'b0);
      check_flag("rsp_timeout pulsed", to_pulses != t0, 1'b0);
    end else if (answer) begin
      check_flag("read_rdy once", (rdy_pulses - r0) == 1, 1'b1);
      check_flag("rsp_timeout pulsed", to_pulses != t0, 1'b0);
      check_byte("read_data", got_data, rsp);
      check_flag("read_err", got_err, bad_par);
    end else begin
      check_flag("rsp_timeout once", (to_pulses - t0) == 1, 1'b1);
      check_flag("read_rdy pulsed", rdy_pulses != r0, 1'b0);
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    $display("test %-10s done, %0d errors", name, errors - e0);
  endtask

  task automatic test_write();
    int e0;
    e0 = errors;
    run_cmd(16'h12A5, 1'b0, 8'h00, 1'b0, 0, 1'b0, '0);
    report_test("write", e0);
  endtask

  task automatic test_read();
    int e0;
    e0 = errors;
    run_cmd(16'h9C07, 1'b1, 8'h3C, 1'b0, 20, 1'b0, '0);
    report_test("read", e0);
  endtask

  task automatic test_bad_parity();
    int e0;
    e0 = errors;
    run_cmd(16'hB10E, 1'b1, 8'h96, 1'b1, 20, 1'b0, '0);
    report_test("bad_parity", e0);
  endtask

  task automatic test_timeout();
    int e0;
    e0 = errors;
    run_cmd(16'h8077, 1'b0, 8'h00, 1'b0, 0, 1'b0, '0);
    run_cmd(16'h4D2B, 1'b0, 8'h00, 1'b0, 0, 1'b0, '0);
    report_test("timeout", e0);
  endtask

  task automatic test_busy();
    int   e0;
    logic seen_low;
    e0 = errors;
    seen_low = 1'b0;
    run_cmd(16'h5A33, 1'b0, 8'h00, 1'b0, 0, 1'b1, 16'h43E1);
    // a dropped word would start a third frame here
    repeat (3 * BIT_CLKS) begin
      @(negedge clk);
      if (!tx) begin
        seen_low = 1'b1;
      end
    end
    check_flag("extra frame on tx", seen_low, 1'b0);
    report_test("busy", e0);
  endtask

  task automatic test_random();
    int          e0;
    int          gap;
    logic [31:0] r;
    cmd_t        cmd;
    byte_t       rsp;
    e0 = errors;
    for (int k = 0; k < 20; k++) begin
      r   = lcg_next();
      cmd = r[31:16];
      r   = lcg_next();
      rsp = r[23:16];
      gap = 10 + int'(r[5:0]);
      run_cmd(cmd, 1'b1, rsp, 1'b0, gap, 1'b0, '0);
    end
    report_test("random", e0);
  endtask

  initial begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = line_idle;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("cmd_rdy after reset", cmd_rdy, 1'b1);
    check_flag("tx after reset", tx, 1'b1);
    check_flag("read_rdy after reset", read_rdy, 1'b0);
    check_flag("rsp_timeout after reset", rsp_timeout, 1'b0);
    test_write();
    test_read();
    test_bad_parity();
    test_timeout();
    test_busy();
    test_random();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/uart_frame_pkg.sv
verilog/bridge_cmd_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/cmd_sequencer.sv
verilog/uart_cmd_bridge.sv
sim/tb_uart_cmd_bridge.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP   = tb_uart_cmd_bridge
FLIST = filelist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
